//--- ex_alu.sv
`timescale 1ns/100ps

module ex_alu
    import ex_pkg::*;
(
    input  alu_op_t alu_op_i,
    input  word_t   opdata1_i,
    input  word_t   opdata2_i,
    output word_t   result_o,
    output logic    overflow_o,
    output logic    move_cancel_o
);

    word_t sum;
    word_t diff;
    logic  add_ov;
    logic  sub_ov;
    logic  lt_signed;
    logic  lt_unsigned;
    logic  [4:0] shamt;

    // ----------------------------------------
    // shared arithmetic
    // ----------------------------------------
    assign sum  = opdata1_i + opdata2_i;
    assign diff = opdata1_i - opdata2_i;

    // same-sign inputs, sign flips in the sum
    assign add_ov = (opdata1_i[31] == opdata2_i[31]) && (sum[31] != opdata1_i[31]);
    // opposite-sign inputs, result takes the subtrahend sign
    assign sub_ov = (opdata1_i[31] != opdata2_i[31]) && (diff[31] != opdata1_i[31]);

    assign lt_signed   = $signed(opdata1_i) < $signed(opdata2_i);
    assign lt_unsigned = opdata1_i < opdata2_i;

    // shift amount in opdata1, value to shift in opdata2
    assign shamt = opdata1_i[4:0];

    // ----------------------------------------
    // result select
    // ----------------------------------------
    always_comb begin
        case (alu_op_i)
            OP_ADD, OP_ADDU, OP_MEM: result_o = sum;
            OP_SUB, OP_SUBU:         result_o = diff;
            OP_AND:                  result_o = opdata1_i & opdata2_i;
            OP_OR:                   result_o = opdata1_i | opdata2_i;
            OP_XOR:                  result_o = opdata1_i ^ opdata2_i;
            OP_NOR:                  result_o = ~(opdata1_i | opdata2_i);
            OP_SLT:                  result_o = {31'b0, lt_signed};
            OP_SLTU:                 result_o = {31'b0, lt_unsigned};
            OP_SLL:                  result_o = opdata2_i << shamt;
            OP_SRL:                  result_o = opdata2_i >> shamt;
            OP_SRA:                  result_o = $signed(opdata2_i) >>> shamt;
            OP_LUI:                  result_o = {opdata2_i[15:0], 16'b0};
            OP_MOVN, OP_MOVZ:        result_o = opdata1_i;
            default:                 result_o = '0;
        endcase
    end

    always_comb begin
        case (alu_op_i)
            OP_ADD:  overflow_o = add_ov;
            OP_SUB:  overflow_o = sub_ov;
            default: overflow_o = 1'b0;
        endcase
    end

    // move condition fails, so the write is dropped
    always_comb begin
        case (alu_op_i)
            OP_MOVN: move_cancel_o = (opdata2_i == '0);
            OP_MOVZ: move_cancel_o = (opdata2_i != '0);
            default: move_cancel_o = 1'b0;
        endcase
    end

endmodule

//--- ex_branch_unit.sv
`timescale 1ns/100ps

module ex_branch_unit
    import ex_pkg::*;
(
    input  alu_op_t alu_op_i,
    input  word_t   opdata1_i,
    input  word_t   opdata2_i,
    input  word_t   branch_addr_i,
    output logic    is_branch_o,
    output logic    taken_o,
    output word_t   target_o
);

    logic equal;

    assign equal = (opdata1_i == opdata2_i);

    always_comb begin
        is_branch_o = 1'b1;
        case (alu_op_i)
            OP_BEQ:     taken_o = equal;
            OP_BNE:     taken_o = !equal;
            OP_BLTZ:    taken_o = opdata1_i[31];
            OP_BGEZ:    taken_o = !opdata1_i[31];
            OP_J, OP_JR: taken_o = 1'b1;
            default: begin
                is_branch_o = 1'b0;
                taken_o     = 1'b0;
            end
        endcase
    end

    // register jump uses rs, the rest use the decoded address
    assign target_o = (alu_op_i == OP_JR) ? opdata1_i : branch_addr_i;

endmodule

//--- ex_muldiv.sv
`timescale 1ns/100ps

module ex_muldiv
    import ex_pkg::*;
(
    input  logic   clk,
    input  logic   reset_i,
    input  logic   abort_i,
    input  logic   start_i,
    input  logic   signed_i,
    input  logic   divide_i,
    input  word_t  opdata1_i,
    input  word_t  opdata2_i,
    input  logic   ack_i,
    output logic   done_o,
    output dword_t result_o
);

    muldiv_state_t           state_q;
    logic [MULDIV_CNT_W-1:0] step_q;

    // acc holds product, or remainder:quotient while dividing
    dword_t acc_q;
    dword_t acc_next;
    word_t  operand_q;
    logic   divide_q;
    logic   neg_lo_q;
    logic   neg_hi_q;
    logic   div_zero_q;

    logic   neg1;
    logic   neg2;
    word_t  mag1;
    word_t  mag2;

    assign neg1 = signed_i && opdata1_i[31];
    assign neg2 = signed_i && opdata2_i[31];
    assign mag1 = neg1 ? -opdata1_i : opdata1_i;
    assign mag2 = neg2 ? -opdata2_i : opdata2_i;

    // ----------------------------------------
    // one iteration step
    // ----------------------------------------
    word_t       mul_addend;
    logic [32:0] mul_sum;
    logic [32:0] div_diff;

    assign mul_addend = acc_q[0] ? operand_q : '0;
    assign mul_sum    = {1'b0, acc_q[63:32]} + {1'b0, mul_addend};
    // partial remainder after the left shift needs 33 bits
    assign div_diff   = acc_q[63:31] - {1'b0, operand_q};

    always_comb begin
        if (divide_q) begin
            if (!div_diff[32]) begin
                acc_next = {div_diff[31:0], acc_q[30:0], 1'b1};
            end else begin
                acc_next = {acc_q[62:0], 1'b0};
            end
        end else begin
            acc_next = {mul_sum, acc_q[31:1]};
        end
    end

    // ----------------------------------------
    // control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i || abort_i) begin
            state_q <= MD_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                MD_IDLE: begin
                    if (start_i) begin
                        state_q <= MD_BUSY;
                        step_q  <= '0;
                    end
                end
                MD_BUSY: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == MULDIV_CNT_W'(MULDIV_STEPS - 1)) begin
                        state_q <= MD_DONE;
                    end
                end
                MD_DONE: begin
                    if (ack_i) begin
                        state_q <= MD_IDLE;
                    end
                end
                default: state_q <= MD_IDLE;
            endcase
        end
    end

    // datapath loaded on start and stepped while busy
    always_ff @(posedge clk) begin
        if (state_q == MD_IDLE && start_i) begin
            acc_q      <= {32'b0, mag1};
            operand_q  <= mag2;
            divide_q   <= divide_i;
            neg_lo_q   <= neg1 ^ neg2;
            neg_hi_q   <= neg1;
            div_zero_q <= divide_i && (opdata2_i == '0);
        end else if (state_q == MD_BUSY) begin
            acc_q <= acc_next;
        end
    end

    // ----------------------------------------
    // sign fix
    // ----------------------------------------
    dword_t prod_fixed;
    word_t  quot_fixed;
    word_t  rem_fixed;

    assign prod_fixed = neg_lo_q ? -acc_q : acc_q;
    assign quot_fixed = div_zero_q ? '1 : (neg_lo_q ? -acc_q[31:0] : acc_q[31:0]);
    // remainder follows the dividend sign
    assign rem_fixed  = neg_hi_q ? -acc_q[63:32] : acc_q[63:32];

    assign result_o = divide_q ? {rem_fixed, quot_fixed} : prod_fixed;
    assign done_o   = (state_q == MD_DONE);

endmodule

//--- ex_pkg.sv
package ex_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int WORD_W     = 32;
    localparam int DWORD_W    = 64;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 8;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [DWORD_W-1:0]    dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ALU_OP_W-1:0]   alu_op_t;

    // ----------------------------------------
    // operation codes
    // ----------------------------------------
    localparam alu_op_t OP_ADD   = 8'h01;
    localparam alu_op_t OP_ADDU  = 8'h02;
    localparam alu_op_t OP_SUB   = 8'h03;
    localparam alu_op_t OP_SUBU  = 8'h04;
    localparam alu_op_t OP_AND   = 8'h05;
    localparam alu_op_t OP_OR    = 8'h06;
    localparam alu_op_t OP_XOR   = 8'h07;
    localparam alu_op_t OP_NOR   = 8'h08;
    localparam alu_op_t OP_SLT   = 8'h09;
    localparam alu_op_t OP_SLTU  = 8'h0a;
    localparam alu_op_t OP_SLL   = 8'h10;
    localparam alu_op_t OP_SRL   = 8'h11;
    localparam alu_op_t OP_SRA   = 8'h12;
    localparam alu_op_t OP_LUI   = 8'h13;
    localparam alu_op_t OP_MOVN  = 8'h18;
    localparam alu_op_t OP_MOVZ  = 8'h19;
    localparam alu_op_t OP_MULT  = 8'h20;
    localparam alu_op_t OP_MULTU = 8'h21;
    localparam alu_op_t OP_DIV   = 8'h22;
    localparam alu_op_t OP_DIVU  = 8'h23;
    localparam alu_op_t OP_BEQ   = 8'h30;
    localparam alu_op_t OP_BNE   = 8'h31;
    localparam alu_op_t OP_BLTZ  = 8'h32;
    localparam alu_op_t OP_BGEZ  = 8'h33;
    localparam alu_op_t OP_J     = 8'h34;
    localparam alu_op_t OP_JR    = 8'h35;
    localparam alu_op_t OP_MEM   = 8'h40;

    // multiply/divide iteration count
    localparam int MULDIV_STEPS = 32;
    localparam int MULDIV_CNT_W = $clog2(MULDIV_STEPS);

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_BUSY,
        MD_DONE
    } muldiv_state_t;

    // true for ops handled by the multiply/divide unit
    function automatic logic is_muldiv(alu_op_t op);
        return (op == OP_MULT) || (op == OP_MULTU) || (op == OP_DIV) || (op == OP_DIVU);
    endfunction

endpackage

//--- ex_stage.sv
`timescale 1ns/100ps

module ex_stage
    import ex_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      flush_i,
    input  logic      id_valid_i,
    input  word_t     inst_addr_i,
    input  logic      reg_write_i,
    input  reg_addr_t reg_waddr_i,
    input  alu_op_t   alu_op_i,
    input  word_t     opdata1_i,
    input  word_t     opdata2_i,
    input  word_t     branch_addr_i,
    input  logic      mem_allowin_i,
    output logic      ex_allowin_o,
    output logic      ex_mem_valid_o,
    output word_t     inst_addr_o,
    output logic      reg_write_o,
    output reg_addr_t reg_waddr_o,
    output word_t     reg_wdata_o,
    output logic      overflow_o,
    output logic      hilo_write_o,
    output dword_t    hilo_wdata_o,
    output logic      branch_valid_o,
    output logic      branch_taken_o,
    output word_t     branch_target_o
);

    // ----------------------------------------
    // stage register and handshake
    // ----------------------------------------
    logic      valid_q;
    word_t     inst_addr_q;
    logic      reg_write_q;
    reg_addr_t reg_waddr_q;
    alu_op_t   alu_op_q;
    word_t     opdata1_q;
    word_t     opdata2_q;
    word_t     branch_addr_q;

    logic ready_go;
    logic accept;
    logic transfer;
    logic is_md;
    logic md_started_q;
    logic md_start;
    logic md_done;

    assign is_md    = is_muldiv(alu_op_q);
    assign ready_go = !flush_i && (!is_md || md_done);
    assign ex_allowin_o   = !valid_q || (ready_go && mem_allowin_i);
    assign ex_mem_valid_o = valid_q && ready_go;
    assign accept   = ex_allowin_o && id_valid_i;
    assign transfer = ex_mem_valid_o && mem_allowin_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (ex_allowin_o) begin
            valid_q <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_addr_q   <= inst_addr_i;
            reg_write_q   <= reg_write_i;
            reg_waddr_q   <= reg_waddr_i;
            alu_op_q      <= alu_op_i;
            opdata1_q     <= opdata1_i;
            opdata2_q     <= opdata2_i;
            branch_addr_q <= branch_addr_i;
        end
    end

    // ----------------------------------------
    // execution units
    // ----------------------------------------
    logic  move_cancel;
    logic  alu_overflow;
    word_t alu_result;
    logic  is_branch;

    ex_alu u_alu (
        .alu_op_i      (alu_op_q),
        .opdata1_i     (opdata1_q),
        .opdata2_i     (opdata2_q),
        .result_o      (alu_result),
        .overflow_o    (alu_overflow),
        .move_cancel_o (move_cancel)
    );

    // start flag clears when the next instruction loads
    always_ff @(posedge clk) begin
        if (reset_i || flush_i || accept) begin
            md_started_q <= 1'b0;
        end else if (md_start) begin
            md_started_q <= 1'b1;
        end
    end

    assign md_start = valid_q && is_md && !md_started_q && !flush_i;

    ex_muldiv u_muldiv (
        .clk       (clk),
        .reset_i   (reset_i),
        .abort_i   (flush_i),
        .start_i   (md_start),
        .signed_i  ((alu_op_q == OP_MULT) || (alu_op_q == OP_DIV)),
        .divide_i  ((alu_op_q == OP_DIV) || (alu_op_q == OP_DIVU)),
        .opdata1_i (opdata1_q),
        .opdata2_i (opdata2_q),
        .ack_i     (transfer && is_md),
        .done_o    (md_done),
        .result_o  (hilo_wdata_o)
    );

    ex_branch_unit u_branch (
        .alu_op_i      (alu_op_q),
        .opdata1_i     (opdata1_q),
        .opdata2_i     (opdata2_q),
        .branch_addr_i (branch_addr_q),
        .is_branch_o   (is_branch),
        .taken_o       (branch_taken_o),
        .target_o      (branch_target_o)
    );

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    assign inst_addr_o  = inst_addr_q;
    assign reg_waddr_o  = reg_waddr_q;
    assign reg_wdata_o  = alu_result;
    assign overflow_o   = alu_overflow;
    // failed move or overflow drops the register write
    assign reg_write_o  = reg_write_q && !move_cancel && !alu_overflow;

    assign hilo_write_o   = transfer && is_md;
    assign branch_valid_o = transfer && is_branch;

endmodule

//--- filelist.f
ex_pkg.sv
ex_alu.sv
ex_muldiv.sv
ex_branch_unit.sv
ex_stage.sv
tb_clock_gen.sv
tb_ex_stage.sv

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset_i
);

    localparam real HALF_PERIOD  = 2.0;
    localparam int  RESET_CYCLES = 8;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
    end

endmodule

//--- tb_ex_stage.sv
`timescale 1ns/100ps

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int    CLK_PERIOD      = 4;
    // instructions issued over all tests
    localparam int    NUM_TESTS       = 49;
    localparam int    WATCHDOG_CYCLES = NUM_TESTS * 100 + 500;
    localparam int    WAIT_LIMIT      = 100;
    localparam word_t LFSR_SEED       = 32'hfea66e2f;
    localparam word_t LFSR_TAPS       = 32'h80200003;

    logic      clk;
    logic      reset_i;
    logic      flush_i;
    logic      id_valid_i;
    word_t     inst_addr_i;
    logic      reg_write_i;
    reg_addr_t reg_waddr_i;
    alu_op_t   alu_op_i;
    word_t     opdata1_i;
    word_t     opdata2_i;
    word_t     branch_addr_i;
    logic      mem_allowin_i;
    logic      ex_allowin_o;
    logic      ex_mem_valid_o;
    word_t     inst_addr_o;
    logic      reg_write_o;
    reg_addr_t reg_waddr_o;
    word_t     reg_wdata_o;
    logic      overflow_o;
    logic      hilo_write_o;
    dword_t    hilo_wdata_o;
    logic      branch_valid_o;
    logic      branch_taken_o;
    word_t     branch_target_o;

    word_t lfsr_q;
    word_t pc;
    int    error_count;
    int    check_count;

    tb_clock_gen u_clock_gen (
        .clk     (clk),
        .reset_i (reset_i)
    );

    ex_stage uut (
        .clk             (clk),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .id_valid_i      (id_valid_i),
        .inst_addr_i     (inst_addr_i),
        .reg_write_i     (reg_write_i),
        .reg_waddr_i     (reg_waddr_i),
        .alu_op_i        (alu_op_i),
        .opdata1_i       (opdata1_i),
        .opdata2_i       (opdata2_i),
        .branch_addr_i   (branch_addr_i),
        .mem_allowin_i   (mem_allowin_i),
        .ex_allowin_o    (ex_allowin_o),
        .ex_mem_valid_o  (ex_mem_valid_o),
        .inst_addr_o     (inst_addr_o),
        .reg_write_o     (reg_write_o),
        .reg_waddr_o     (reg_waddr_o),
        .reg_wdata_o     (reg_wdata_o),
        .overflow_o      (overflow_o),
        .hilo_write_o    (hilo_write_o),
        .hilo_wdata_o    (hilo_wdata_o),
        .branch_valid_o  (branch_valid_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o)
    );

    // ----------------------------------------
    // random operands
    // ----------------------------------------
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q  = (lfsr_q >> 1) ^ (out_bit ? LFSR_TAPS : 32'h0);
        return out_bit;
    endfunction

    function automatic word_t rand_bits(int n);
        word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], lfsr_step()};
        end
        return w;
    endfunction

    // sign-extended 12-bit value for divides with wider quotients
    function automatic word_t small_operand();
        word_t r;
        r = rand_bits(12);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic word_t model_result(alu_op_t op, word_t a, word_t b);
        word_t fill;
        fill = b[31] ? ~(32'hffffffff >> a[4:0]) : 32'h0;
        case (op)
            OP_ADD, OP_ADDU, OP_MEM: return a + b;
            OP_SUB, OP_SUBU:         return a - b;
            OP_AND:                  return a & b;
            OP_OR:                   return a | b;
            OP_XOR:                  return a ^ b;
            OP_NOR:                  return ~(a | b);
            OP_SLT:                  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU:                 return (a < b) ? 32'd1 : 32'd0;
            OP_SLL:                  return b << a[4:0];
            OP_SRL:                  return b >> a[4:0];
            OP_SRA:                  return (b >> a[4:0]) | fill;
            OP_LUI:                  return {b[15:0], 16'h0};
            OP_MOVN, OP_MOVZ:        return a;
            default:                 return 32'h0;
        endcase
    endfunction

    // result outside the signed 32-bit range
    function automatic logic model_overflow(alu_op_t op, word_t a, word_t b);
        longint wide;
        wide = 0;
        if (op == OP_ADD) begin
            wide = longint'($signed(a)) + longint'($signed(b));
        end else if (op == OP_SUB) begin
            wide = longint'($signed(a)) - longint'($signed(b));
        end
        return (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
    endfunction

    function automatic logic model_cancel(alu_op_t op, word_t b);
        return ((op == OP_MOVN) && (b == 0)) || ((op == OP_MOVZ) && (b != 0));
    endfunction

    function automatic dword_t model_hilo(alu_op_t op, word_t a, word_t b);
        longint sa;
        longint sb;
        longint q;
        longint r;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        if ((op == OP_DIV || op == OP_DIVU) && b == 0) begin
            return {a, 32'hffffffff};
        end
        case (op)
            OP_MULT:  return dword_t'(sa * sb);
            OP_MULTU: return {32'h0, a} * {32'h0, b};
            OP_DIV: begin
                q = sa / sb;
                r = sa % sb;
                return {word_t'(r), word_t'(q)};
            end
            OP_DIVU:  return {a % b, a / b};
            default:  return 64'h0;
        endcase
    endfunction

    function automatic logic model_taken(alu_op_t op, word_t a, word_t b);
        case (op)
            OP_BEQ:      return a == b;
            OP_BNE:      return a != b;
            OP_BLTZ:     return $signed(a) < 0;
            OP_BGEZ:     return $signed(a) >= 0;
            OP_J, OP_JR: return 1'b1;
            default:     return 1'b0;
        endcase
    endfunction

    // ----------------------------------------
    // driving and checking
    // ----------------------------------------
    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // called at a falling edge, returns on the accepting rising edge
    task automatic send_instr(input alu_op_t op, input word_t a, input word_t b,
                              input word_t baddr, input reg_addr_t waddr, input logic wr);
        int waited;
        waited = 0;
        while (!ex_allowin_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!ex_allowin_o) begin
            error_count++;
            $display("stage never became ready for a new instruction at %0d ns", $time);
        end
        pc = pc + 32'd4;
        @(posedge clk);
        id_valid_i    <= 1'b1;
        inst_addr_i   <= pc;
        reg_write_i   <= wr;
        reg_waddr_i   <= waddr;
        alu_op_i      <= op;
        opdata1_i     <= a;
        opdata2_i     <= b;
        branch_addr_i <= baddr;
        @(posedge clk);
        id_valid_i <= 1'b0;
    endtask

    task automatic wait_result(output logic found);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!ex_mem_valid_o && waited < WAIT_LIMIT) begin
            if (ex_allowin_o) begin
                error_count++;
                $display("stage allowed new input while still busy at %0d ns", $time);
            end
            @(negedge clk);
            waited++;
        end
        found = ex_mem_valid_o;
        if (!found) begin
            error_count++;
            $display("timed out waiting for a result from the stage at %0d ns", $time);
        end
    endtask

    // one cycle after transfer the stage is empty again
    task automatic check_stage_empty(input alu_op_t op);
        @(negedge clk);
        check_value($sformatf("op %h ex_mem_valid_o after", op), ex_mem_valid_o, 0);
        check_value($sformatf("op %h branch_valid_o after", op), branch_valid_o, 0);
        check_value($sformatf("op %h hilo_write_o after", op), hilo_write_o, 0);
        check_value($sformatf("op %h ex_allowin_o after", op), ex_allowin_o, 1);
    endtask

    task automatic run_alu(input alu_op_t op, input word_t a, input word_t b);
        reg_addr_t waddr;
        logic      found;
        logic      exp_ov;
        waddr  = reg_addr_t'(rand_bits(5));
        exp_ov = model_overflow(op, a, b);
        send_instr(op, a, b, 32'h0, waddr, 1'b1);
        wait_result(found);
        if (found) begin
            check_value($sformatf("op %h reg_wdata_o", op), reg_wdata_o, model_result(op, a, b));
            check_value($sformatf("op %h reg_write_o", op), reg_write_o,
                        !exp_ov && !model_cancel(op, b));
            check_value($sformatf("op %h overflow_o", op), overflow_o, exp_ov);
            check_value($sformatf("op %h reg_waddr_o", op), reg_waddr_o, waddr);
            check_value($sformatf("op %h inst_addr_o", op), inst_addr_o, pc);
            check_value($sformatf("op %h hilo_write_o", op), hilo_write_o, 0);
            check_value($sformatf("op %h branch_valid_o", op), branch_valid_o, 0);
        end
        check_stage_empty(op);
    endtask

    task automatic run_muldiv(input alu_op_t op, input word_t a, input word_t b);
        logic found;
        send_instr(op, a, b, 32'h0, 5'd0, 1'b0);
        wait_result(found);
        if (found) begin
            check_value($sformatf("op %h hilo_write_o", op), hilo_write_o, 1);
            check_value($sformatf("op %h hilo_wdata_o", op), hilo_wdata_o, model_hilo(op, a, b));
        end
        check_stage_empty(op);
    endtask

    task automatic run_branch(input alu_op_t op, input word_t a, input word_t b,
                              input word_t baddr);
        logic found;
        send_instr(op, a, b, baddr, 5'd0, 1'b0);
        wait_result(found);
        if (found) begin
            check_value($sformatf("op %h branch_valid_o", op), branch_valid_o, 1);
            check_value($sformatf("op %h branch_taken_o", op), branch_taken_o,
                        model_taken(op, a, b));
            check_value($sformatf("op %h branch_target_o", op), branch_target_o,
                        (op == OP_JR) ? a : baddr);
        end
        check_stage_empty(op);
    endtask

    // memory stage refuses the result for a while, then takes it
    task automatic hold_and_release(input alu_op_t op, input word_t a, input word_t b,
                                    input int cycles);
        logic   found;
        word_t  exp_data;
        dword_t exp_hilo;
        exp_data = model_result(op, a, b);
        exp_hilo = model_hilo(op, a, b);
        send_instr(op, a, b, 32'h0, 5'd1, 1'b1);
        mem_allowin_i <= 1'b0;
        wait_result(found);
        if (found) begin
            repeat (cycles) begin
                @(negedge clk);
                check_value("held ex_mem_valid_o", ex_mem_valid_o, 1);
                check_value("held ex_allowin_o", ex_allowin_o, 0);
                check_value("held hilo_write_o", hilo_write_o, 0);
                if (is_muldiv(op)) begin
                    check_value("held hilo_wdata_o", hilo_wdata_o, exp_hilo);
                end else begin
                    check_value("held reg_wdata_o", reg_wdata_o, exp_data);
                end
            end
        end
        @(posedge clk);
        mem_allowin_i <= 1'b1;
        @(negedge clk);
        check_value("released ex_mem_valid_o", ex_mem_valid_o, 1);
        check_value("released ex_allowin_o", ex_allowin_o, 1);
        if (is_muldiv(op)) begin
            check_value("released hilo_write_o", hilo_write_o, 1);
            check_value("released hilo_wdata_o", hilo_wdata_o, exp_hilo);
        end else begin
            check_value("released hilo_write_o", hilo_write_o, 0);
            check_value("released reg_wdata_o", reg_wdata_o, exp_data);
        end
        check_stage_empty(op);
    endtask

    task automatic flush_during_muldiv();
        send_instr(OP_MULT, rand_bits(32), rand_bits(32), 32'h0, 5'd0, 1'b0);
        repeat (4) begin
            @(negedge clk);
            check_value("busy ex_mem_valid_o", ex_mem_valid_o, 0);
            check_value("busy ex_allowin_o", ex_allowin_o, 0);
        end
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        // the abandoned multiply must never show up
        repeat (MULDIV_STEPS + 8) begin
            @(negedge clk);
            check_value("flushed ex_mem_valid_o", ex_mem_valid_o, 0);
            check_value("flushed hilo_write_o", hilo_write_o, 0);
            check_value("flushed ex_allowin_o", ex_allowin_o, 1);
        end
    endtask

    // ----------------------------------------
    // test sequences
    // ----------------------------------------
    task automatic test_alu_ops();
        alu_op_t op_list [15];
        op_list = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
                    OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_LUI, OP_MEM};
        for (int i = 0; i < 15; i++) begin
            run_alu(op_list[i], rand_bits(32), rand_bits(32));
        end
    endtask

    task automatic test_overflow_and_moves();
        run_alu(OP_ADD, 32'h7fffffff, 32'h00000001);
        run_alu(OP_ADD, 32'h80000000, 32'h80000000);
        run_alu(OP_SUB, 32'h80000000, 32'h00000001);
        run_alu(OP_ADDU, 32'h7fffffff, 32'h00000001);
        run_alu(OP_SUBU, 32'h80000000, 32'h00000001);
        run_alu(OP_MOVN, rand_bits(32), 32'h0);
        run_alu(OP_MOVN, rand_bits(32), 32'h00000005);
        run_alu(OP_MOVZ, rand_bits(32), 32'h0);
        run_alu(OP_MOVZ, rand_bits(32), 32'h00000100);
    endtask

    task automatic test_muldiv();
        alu_op_t md_ops [4];
        md_ops = '{OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
        for (int i = 0; i < 4; i++) begin
            run_muldiv(md_ops[i], rand_bits(32), rand_bits(32));
            run_muldiv(md_ops[i], rand_bits(32), small_operand());
        end
        run_muldiv(OP_DIV, rand_bits(32), 32'h0);
        run_muldiv(OP_DIVU, rand_bits(32), 32'h0);
    endtask

    task automatic test_branches();
        word_t a;
        a = rand_bits(32);
        run_branch(OP_BEQ, a, a, rand_bits(32));
        run_branch(OP_BEQ, a, a ^ 32'h1, rand_bits(32));
        run_branch(OP_BNE, a, a, rand_bits(32));
        run_branch(OP_BNE, a, ~a, rand_bits(32));
        run_branch(OP_BLTZ, a | 32'h80000000, 32'h0, rand_bits(32));
        run_branch(OP_BLTZ, a & 32'h7fffffff, 32'h0, rand_bits(32));
        run_branch(OP_BGEZ, a | 32'h80000000, 32'h0, rand_bits(32));
        run_branch(OP_BGEZ, a & 32'h7fffffff, 32'h0, rand_bits(32));
        run_branch(OP_J, rand_bits(32), rand_bits(32), rand_bits(32));
        run_branch(OP_JR, rand_bits(32), rand_bits(32), rand_bits(32));
    endtask

    // ----------------------------------------
    // main sequence and watchdog
    // ----------------------------------------
    initial begin
        lfsr_q      = LFSR_SEED;
        pc          = 32'h0040_0000;
        error_count = 0;
        check_count = 0;

        flush_i       <= 1'b0;
        id_valid_i    <= 1'b0;
        inst_addr_i   <= '0;
        reg_write_i   <= 1'b0;
        reg_waddr_i   <= '0;
        alu_op_i      <= '0;
        opdata1_i     <= '0;
        opdata2_i     <= '0;
        branch_addr_i <= '0;
        mem_allowin_i <= 1'b1;

        @(negedge clk);
        while (reset_i) @(negedge clk);
        check_value("ex_allowin_o after reset", ex_allowin_o, 1);
        check_value("ex_mem_valid_o after reset", ex_mem_valid_o, 0);
        check_value("branch_valid_o after reset", branch_valid_o, 0);
        check_value("hilo_write_o after reset", hilo_write_o, 0);

        test_alu_ops();
        test_overflow_and_moves();
        test_muldiv();
        test_branches();
        hold_and_release(OP_ADDU, rand_bits(32), rand_bits(32), 6);
        hold_and_release(OP_MULTU, rand_bits(32), rand_bits(32), 6);
        flush_during_muldiv();
        run_alu(OP_XOR, rand_bits(32), rand_bits(32));
        run_muldiv(OP_DIV, rand_bits(32), small_operand());

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not complete",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
